/* list.f */
design/clkmon_pkg.sv
design/clkmon_gate_gen.sv
design/freq_counter.sv
design/clkmon_regs.sv
design/clkmon_top.sv
verification/clkmon_tb.sv

/* Makefile */
# Verilator build and run for the clock frequency monitor.

TOP = clkmon_tb

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f list.f

# The simulator status is masked by tee; the log search decides.
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

/* verification/clkmon_patterns.txt */
# P ch half_period (decimal) | W addr data strb resp (hex) | R addr data resp (hex)
# A cycles | N windows | M ch expected tolerance (all decimal)
P 0 35
P 1 50
P 2 125
P 3 18
# Values after reset.
R 00 0c1c0001 0
R 04 000003e8 0
R 08 00000000 0
R 10 00000000 0
R 14 00000000 0
R 18 00000000 0
R 1c 00000000 0
# Unmapped and misaligned reads.
R 0c 00000000 2
R 20 00000000 2
R 12 00000000 2
# Writes to read-only and unmapped offsets.
W 00 ffffffff f 2
W 08 12345678 f 2
W 0c 000001f4 f 2
R 00 0c1c0001 0
R 04 000003e8 0
A 1100
N 3
M 0 1429 2
M 1 1000 2
M 2 400 2
M 3 2778 2
# Gate length writes, clamp and byte strobes.
W 04 000001f4 f 0
R 04 000001f4 0
W 04 0000000a f 0
R 04 00000040 0
W 04 000001f4 f 0
W 04 ffff0300 2 0
R 04 000003f4 0
W 04 000001f4 f 0
R 04 000001f4 0
N 3
M 0 714 2
M 1 500 2
M 2 200 2
M 3 1389 2

/* verification/clkmon_tb.sv */
module clkmon_tb;

	logic                                  hw;
	logic                                  rst_n;
	logic [clkmon_pkg::NUM_CLK-1:0]        fin;
	logic [clkmon_pkg::ADDR_WIDTH-1:0]     awaddr;
	logic                                  awvalid;
	logic                                  awready;
	logic [clkmon_pkg::FREQ_WIDTH-1:0]     wdata;
	logic [clkmon_pkg::FREQ_WIDTH/8-1:0]   wstrb;
	logic                                  wvalid;
	logic                                  wready;
	logic [1:0]                            bresp;
	logic                                  bvalid;
	logic                                  bready;
	logic [clkmon_pkg::ADDR_WIDTH-1:0]     araddr;
	logic                                  arvalid;
	logic                                  arready;
	logic [clkmon_pkg::FREQ_WIDTH-1:0]     rdata;
	logic [1:0]                            rresp;
	logic                                  rvalid;
	logic                                  rready;

	int fin_half [clkmon_pkg::NUM_CLK] = '{default: 50};  // Set by P lines.
	int hs_timeout  = 200;                                 // Cycles per handshake.
	int win_timeout = 5000;                                // Polls per window wait.
	int errors      = 0;
	int checks      = 0;
	int seed        = 32'ha0ca1c72;                        // Stall lengths.

	clkmon_top u_clkmon_top (.*);

	always #50 hw = ~hw;  // 100 unit reference period.

	// Monitored clocks, each with its own half period.
	for (genvar i = 0; i < clkmon_pkg::NUM_CLK; i++) begin : gen_fin
		logic clk = 1'b0;
		always begin
			#(fin_half[i]);
			clk = ~clk;
		end
		assign fin[i] = clk;
	end

	task automatic next_cycle();
		@(posedge hw);
		#5;  // Drive skew.
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int wait_cnt;
		int stall;
		resp     = 'x;
		awaddr   = addr;
		wdata    = data;
		wstrb    = strb;
		awvalid  = 1'b1;
		wvalid   = 1'b1;
		wait_cnt = 0;
		@(negedge hw);                                  // Mid-cycle sample point.
		while (!(awready && wready) && wait_cnt < hs_timeout) begin
			@(negedge hw);
			wait_cnt++;
		end
		if (!(awready && wready)) begin
			errors++;
			$display("Timeout waiting for awready and wready at %0t", $time);
		end
		next_cycle();                                   // Handshake edge.
		awvalid = 1'b0;
		wvalid  = 1'b0;
		stall   = $unsigned($random(seed)) % 4;
		for (int i = 0; i < stall; i++) begin
			next_cycle();                               // bready held low.
		end
		bready   = 1'b1;
		wait_cnt = 0;
		@(negedge hw);
		while (!bvalid && wait_cnt < hs_timeout) begin
			@(negedge hw);
			wait_cnt++;
		end
		if (!bvalid) begin
			errors++;
			$display("Timeout waiting for bvalid at %0t", $time);
		end else begin
			resp = bresp;
		end
		next_cycle();
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int wait_cnt;
		int stall;
		data     = 'x;
		resp     = 'x;
		araddr   = addr;
		arvalid  = 1'b1;
		wait_cnt = 0;
		@(negedge hw);
		while (!arready && wait_cnt < hs_timeout) begin
			@(negedge hw);
			wait_cnt++;
		end
		if (!arready) begin
			errors++;
			$display("Timeout waiting for arready at %0t", $time);
		end
		next_cycle();
		arvalid = 1'b0;
		stall   = $unsigned($random(seed)) % 4;
		for (int i = 0; i < stall; i++) begin
			next_cycle();                               // rready held low.
		end
		rready   = 1'b1;
		wait_cnt = 0;
		@(negedge hw);
		while (!rvalid && wait_cnt < hs_timeout) begin
			@(negedge hw);
			wait_cnt++;
		end
		if (!rvalid) begin
			errors++;
			$display("Timeout waiting for rvalid at %0t", $time);
		end else begin
			data = rdata;
			resp = rresp;
		end
		next_cycle();
		rready = 1'b0;
	endtask

	// Poll the window counter until it has moved by count.
	task automatic wait_windows(input int count);
		logic [31:0] start;
		logic [31:0] cur;
		logic [1:0]  resp;
		int          polls;
		axi_read(clkmon_pkg::REG_WINDOWS, start, resp);
		cur   = start;
		polls = 0;
		while (cur - start < count && polls < win_timeout) begin
			axi_read(clkmon_pkg::REG_WINDOWS, cur, resp);
			polls++;
		end
		if (cur - start < count) begin
			errors++;
			$display("Timeout waiting for %0d windows at %0t", count, $time);
		end
	endtask

	// Two window reads spaced by a fixed gap.
	task automatic windows_advance(input int cycles);
		logic [31:0] first;
		logic [31:0] second;
		logic [1:0]  resp;
		axi_read(clkmon_pkg::REG_WINDOWS, first, resp);
		for (int i = 0; i < cycles; i++) begin
			next_cycle();
		end
		axi_read(clkmon_pkg::REG_WINDOWS, second, resp);
		check_value(second > first, 1'b1,
			$sformatf("windows %0d then %0d after %0d cycles", first, second, cycles));
	endtask

	task automatic measure(input int ch, input int expected, input int tol);
		logic [31:0] got;
		logic [1:0]  resp;
		int          diff;
		axi_read(clkmon_pkg::REG_FREQ_BASE + 8'(4 * ch), got, resp);
		check_value(resp, clkmon_pkg::RESP_OKAY, $sformatf("channel %0d response", ch));
		diff = int'(got) - expected;
		if (diff < 0) begin
			diff = -diff;
		end
		check_value(diff <= tol, 1'b1, $sformatf("channel %0d reads %0d, expected %0d +- %0d",
			ch, got, expected, tol));
	endtask

	// One pattern line, kind letter already split off.
	task automatic run_command(input logic [7:0] kind, input string rest);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] got;
		logic [1:0]  resp;
		case (kind)
			"P": begin
				void'($sscanf(rest, "%d %d", a, b));
				fin_half[a] = b;
			end
			"W": begin
				void'($sscanf(rest, "%h %h %h %h", a, b, c, d));
				axi_write(a[7:0], b, c[3:0], resp);
				check_value(resp, d, $sformatf("write response at %h", a[7:0]));
			end
			"R": begin
				void'($sscanf(rest, "%h %h %h", a, b, c));
				axi_read(a[7:0], got, resp);
				check_value(got, b, $sformatf("read data at %h", a[7:0]));
				check_value(resp, c, $sformatf("read response at %h", a[7:0]));
			end
			"A": begin
				void'($sscanf(rest, "%d", a));
				windows_advance(a);
			end
			"N": begin
				void'($sscanf(rest, "%d", a));
				wait_windows(a);
			end
			"M": begin
				void'($sscanf(rest, "%d %d %d", a, b, c));
				measure(a, b, c);
			end
			"#", "\n", "\r": begin
			end
			default: begin
				errors++;
				$display("Unknown pattern line kind %s", kind);
			end
		endcase
	endtask

	initial begin
		int    fd;
		int    code;
		string line;
		hw      = 1'b0;
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (3) @(posedge hw);
		#5;
		rst_n = 1'b1;
		fd = $fopen("verification/clkmon_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open verification/clkmon_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0) begin
					run_command(line.getc(0), line.substr(1, line.len() - 1));
				end
			end
			$fclose(fd);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* design/clkmon_top.sv */
module clkmon_top (
	input  logic                                 hw,       // Reference clock.
	input  logic                                 rst_n,
	input  logic [clkmon_pkg::NUM_CLK-1:0]       fin,      // Monitored clocks.
	// AXI4-Lite slave.
	input  logic [clkmon_pkg::ADDR_WIDTH-1:0]    awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [clkmon_pkg::FREQ_WIDTH-1:0]    wdata,
	input  logic [clkmon_pkg::FREQ_WIDTH/8-1:0]  wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	input  logic [clkmon_pkg::ADDR_WIDTH-1:0]    araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	output logic [clkmon_pkg::FREQ_WIDTH-1:0]    rdata,
	output logic [1:0]                           rresp,
	output logic                                 rvalid,
	input  logic                                 rready
);

	logic [clkmon_pkg::GATE_WIDTH-1:0]                        gate_len;   // Regs to timebase.
	logic                                                     gate_tick;  // Shared window.
	logic [clkmon_pkg::FREQ_WIDTH-1:0]                        windows;
	logic [clkmon_pkg::NUM_CLK-1:0][clkmon_pkg::FREQ_WIDTH-1:0] freq_bus;  // All results.

	clkmon_regs u_regs (
		.hw(hw), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.gate_len(gate_len),
		.windows(windows),
		.freq(freq_bus)
	);

	clkmon_gate_gen u_gate_gen (
		.hw(hw),
		.rst_n(rst_n),
		.gate_len(gate_len),
		.gate_tick(gate_tick),
		.windows(windows)
	);

	// One counter per monitored clock, all on the same window.
	for (genvar i = 0; i < clkmon_pkg::NUM_CLK; i++) begin : gen_fcnt
		freq_counter u_fcnt (
			.hw(hw),
			.rst_n(rst_n),
			.fin(fin[i]),
			.gate_tick(gate_tick),
			.freq(freq_bus[i])
		);
	end

endmodule

/* design/clkmon_regs.sv */
module clkmon_regs (
	input  logic                                       hw,
	input  logic                                       rst_n,
	// Write address channel.
	input  logic [clkmon_pkg::ADDR_WIDTH-1:0]          awaddr,
	input  logic                                       awvalid,
	output logic                                       awready,
	// Write data channel.
	input  logic [clkmon_pkg::FREQ_WIDTH-1:0]          wdata,
	input  logic [clkmon_pkg::FREQ_WIDTH/8-1:0]        wstrb,
	input  logic                                       wvalid,
	output logic                                       wready,
	// Write response channel.
	output logic [1:0]                                 bresp,
	output logic                                       bvalid,
	input  logic                                       bready,
	// Read address channel.
	input  logic [clkmon_pkg::ADDR_WIDTH-1:0]          araddr,
	input  logic                                       arvalid,
	output logic                                       arready,
	// Read data channel.
	output logic [clkmon_pkg::FREQ_WIDTH-1:0]          rdata,
	output logic [1:0]                                 rresp,
	output logic                                       rvalid,
	input  logic                                       rready,
	// Monitor side.
	output logic [clkmon_pkg::GATE_WIDTH-1:0]          gate_len,  // Clamped window length.
	input  logic [clkmon_pkg::FREQ_WIDTH-1:0]          windows,
	input  logic [clkmon_pkg::NUM_CLK-1:0][clkmon_pkg::FREQ_WIDTH-1:0] freq
);

	clkmon_pkg::wr_state_e wr_state;
	clkmon_pkg::rd_state_e rd_state;

	logic                              wr_fire;    // Address and data accepted.
	logic                              wr_hit;     // Writable offset.
	logic [clkmon_pkg::FREQ_WIDTH-1:0] wr_merged;  // Old value with strobed bytes.
	logic [clkmon_pkg::GATE_WIDTH-1:0] wr_gate;    // Clamped new length.

	logic                              rd_fire;    // Read address accepted.
	logic [clkmon_pkg::ADDR_WIDTH-1:0] freq_off;   // Offset from frequency base.
	logic                              freq_hit;   // Valid channel word.
	logic [clkmon_pkg::CH_WIDTH-1:0]   freq_ch;    // Channel index.
	logic [clkmon_pkg::FREQ_WIDTH-1:0] rd_word;    // Read mux output.
	logic [1:0]                        rd_resp;

	// Write path.
	assign wr_fire = (wr_state == clkmon_pkg::WR_IDLE) && awvalid && wvalid;
	assign awready = wr_fire;                          // Both ready in one cycle.
	assign wready  = wr_fire;
	assign bvalid  = (wr_state == clkmon_pkg::WR_RESP);
	assign wr_hit  = (awaddr == clkmon_pkg::REG_GATE_LEN);  // Only writable word.

	// Byte merge, then clamp to the shortest safe window.
	always_comb begin
		wr_merged = {{(clkmon_pkg::FREQ_WIDTH - clkmon_pkg::GATE_WIDTH){1'b0}}, gate_len};
		for (int b = 0; b < clkmon_pkg::FREQ_WIDTH / 8; b++) begin
			if (wstrb[b]) begin
				wr_merged[b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
		if (wr_merged[clkmon_pkg::GATE_WIDTH-1:0] < clkmon_pkg::MIN_GATE_LEN) begin
			wr_gate = clkmon_pkg::MIN_GATE_LEN;        // Too short.
		end else begin
			wr_gate = wr_merged[clkmon_pkg::GATE_WIDTH-1:0];  // Top byte dropped.
		end
	end

	always_ff @(posedge hw) begin
		if (!rst_n) begin
			wr_state <= clkmon_pkg::WR_IDLE;
			gate_len <= clkmon_pkg::RESET_GATE_LEN;
		end else begin
			case (wr_state)
				clkmon_pkg::WR_IDLE: begin
					if (wr_fire) begin
						wr_state <= clkmon_pkg::WR_RESP;
						if (wr_hit) begin
							gate_len <= wr_gate;
						end
					end
				end
				clkmon_pkg::WR_RESP: begin
					if (bready) begin
						wr_state <= clkmon_pkg::WR_IDLE;  // Response taken.
					end
				end
			endcase
		end
	end

	always_ff @(posedge hw) begin
		if (wr_fire) begin
			bresp <= wr_hit ? clkmon_pkg::RESP_OKAY : clkmon_pkg::RESP_SLVERR;
		end
	end

	// Read path.
	assign arready  = (rd_state == clkmon_pkg::RD_IDLE);
	assign rvalid   = (rd_state == clkmon_pkg::RD_DATA);
	assign rd_fire  = arready && arvalid;
	assign freq_off = araddr - clkmon_pkg::REG_FREQ_BASE;
	assign freq_ch  = freq_off[2 +: clkmon_pkg::CH_WIDTH];
	assign freq_hit = (araddr >= clkmon_pkg::REG_FREQ_BASE) && (freq_off[1:0] == 2'b00)
		&& (freq_off[clkmon_pkg::ADDR_WIDTH-1:2] < clkmon_pkg::NUM_CLK);

	// Register map.
	always_comb begin
		rd_word = '0;                                  // Unmapped reads zero.
		rd_resp = clkmon_pkg::RESP_OKAY;
		case (araddr)
			clkmon_pkg::REG_REVISION: rd_word = clkmon_pkg::REVISION;
			clkmon_pkg::REG_GATE_LEN: rd_word = clkmon_pkg::FREQ_WIDTH'(gate_len);
			clkmon_pkg::REG_WINDOWS:  rd_word = windows;
			default: begin
				if (freq_hit) begin
					rd_word = freq[freq_ch];           // Per-channel result.
				end else begin
					rd_resp = clkmon_pkg::RESP_SLVERR;
				end
			end
		endcase
	end

	always_ff @(posedge hw) begin
		if (!rst_n) begin
			rd_state <= clkmon_pkg::RD_IDLE;
		end else begin
			case (rd_state)
				clkmon_pkg::RD_IDLE: begin
					if (rd_fire) begin
						rd_state <= clkmon_pkg::RD_DATA;
					end
				end
				clkmon_pkg::RD_DATA: begin
					if (rready) begin
						rd_state <= clkmon_pkg::RD_IDLE;
					end
				end
			endcase
		end
	end

	// Data sampled once at the address handshake, held while rvalid waits.
	always_ff @(posedge hw) begin
		if (rd_fire) begin
			rdata <= rd_word;
			rresp <= rd_resp;
		end
	end

	// A response stays up until the master takes it.
	a_bvalid_hold: assert property (
		@(posedge hw) disable iff (!rst_n)
		(wr_state == clkmon_pkg::WR_RESP) && !bready |=> (wr_state == clkmon_pkg::WR_RESP)
	) else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (
		@(posedge hw) disable iff (!rst_n)
		(rd_state == clkmon_pkg::RD_DATA) && !rready |=> (rd_state == clkmon_pkg::RD_DATA)
	) else $error("rvalid dropped before rready");

	// Frequency words update in the background; the read word must not follow.
	a_rdata_stable: assert property (
		@(posedge hw) disable iff (!rst_n)
		rvalid && !rready |=> $stable(rdata) && $stable(rresp)
	) else $error("rdata changed while rvalid waited");

endmodule

/* design/freq_counter.sv */
module freq_counter (
	input  logic                              hw,
	input  logic                              rst_n,
	input  logic                              fin,        // Monitored clock.
	input  logic                              gate_tick,  // Window boundary in hw domain.
	output logic [clkmon_pkg::FREQ_WIDTH-1:0] freq        // Edges in last window.
);

	// hw domain.
	logic       req_tgl;   // Flips once per tick.
	logic [1:0] ack_sync;  // Ack synchronizer.
	logic       ack_seen;  // Last ack taken.
	logic       ack_chg;   // New ack arrived.
	logic       primed;    // First partial window dropped.

	// fin domain.
	logic [1:0]                        req_sync;  // Request synchronizer.
	logic                              ack_tgl;   // Echo of last request seen.
	logic                              req_chg;   // Window boundary in fin domain.
	logic [clkmon_pkg::FREQ_WIDTH-1:0] edge_cnt;  // Running edge count.
	logic [clkmon_pkg::FREQ_WIDTH-1:0] hold;      // Count of closed window.

	assign req_chg = req_sync[1] ^ ack_tgl;
	assign ack_chg = ack_sync[1] ^ ack_seen;

	// Request side and result capture.
	always_ff @(posedge hw) begin
		if (!rst_n) begin
			req_tgl  <= 1'b0;
			ack_sync <= '0;
			ack_seen <= 1'b0;
			primed   <= 1'b0;
			freq     <= '0;
		end else begin
			if (gate_tick) begin
				req_tgl <= ~req_tgl;                   // Ask fin side to close window.
			end
			ack_sync <= {ack_sync[0], ack_tgl};        // Two flops into hw.
			ack_seen <= ack_sync[1];
			if (ack_chg) begin
				primed <= 1'b1;
				if (primed) begin
					freq <= hold;                      // hold is quiet by now.
				end
			end
		end
	end

	// Monitored clock side. Counts edges between window boundaries.
	always_ff @(posedge fin) begin
		req_sync <= {req_sync[0], req_tgl};            // Two flops into fin.
		ack_tgl  <= req_sync[1];                       // Flips with each boundary.
		if (req_chg) begin
			hold     <= edge_cnt;                      // Close window.
			edge_cnt <= clkmon_pkg::FREQ_WIDTH'(1);    // This edge opens the next.
		end else begin
			edge_cnt <= edge_cnt + 1'b1;
		end
	end

	// The handshake must finish before the gate generator starts the
	// next window, or a boundary is lost.
	a_no_overrun: assert property (
		@(posedge hw) disable iff (!rst_n)
		gate_tick |-> (req_tgl == ack_seen)
	) else $error("gate_tick while request pending");

	// Result only moves when the fin side has acknowledged.
	a_freq_on_ack: assert property (
		@(posedge hw) disable iff (!rst_n)
		$changed(freq) |-> $past(ack_chg)
	) else $error("freq changed without acknowledge");

endmodule

/* design/clkmon_gate_gen.sv */
module clkmon_gate_gen (
	input  logic                                hw,
	input  logic                                rst_n,
	input  logic [clkmon_pkg::GATE_WIDTH-1:0]   gate_len,   // Already clamped.
	output logic                                gate_tick,  // One cycle per window.
	output logic [clkmon_pkg::FREQ_WIDTH-1:0]   windows     // Ticks since reset.
);

	logic [clkmon_pkg::GATE_WIDTH-1:0] remain;  // Cycles left in window.
	logic                              win_end; // Last cycle of window.

	assign win_end = (remain == clkmon_pkg::GATE_WIDTH'(1));

	// Window timebase. Reload only at window end so a new length
	// never cuts a running window short.
	always_ff @(posedge hw) begin
		if (!rst_n) begin
			remain    <= clkmon_pkg::RESET_GATE_LEN;  // First window uses reset length.
			gate_tick <= 1'b0;
		end else begin
			gate_tick <= win_end;                      // Registered pulse.
			if (win_end) begin
				remain <= gate_len;                    // Pick up new length here.
			end else begin
				remain <= remain - 1'b1;
			end
		end
	end

	// Window counter, one behind the tick.
	always_ff @(posedge hw) begin
		if (!rst_n) begin
			windows <= '0;
		end else if (gate_tick) begin
			windows <= windows + 1'b1;                 // Wraps after 2^32 windows.
		end
	end

	// The register block must never hand over a window shorter than
	// the crossing needs.
	a_gate_len_min: assert property (
		@(posedge hw) disable iff (!rst_n)
		gate_len >= clkmon_pkg::MIN_GATE_LEN
	) else $error("gate_len below MIN_GATE_LEN");

	// Ticks stay one cycle wide.
	a_tick_single: assert property (
		@(posedge hw) disable iff (!rst_n)
		gate_tick |=> !gate_tick
	) else $error("gate_tick wider than one cycle");

endmodule

/* design/clkmon_pkg.sv */
package clkmon_pkg;

	// Channel count and data path widths.
	localparam int NUM_CLK    = 4;                // Monitored clocks.
	localparam int FREQ_WIDTH = 32;               // Result and register word.
	localparam int GATE_WIDTH = 24;               // Gate length register.
	localparam int ADDR_WIDTH = 8;                // AXI4-Lite byte address.
	localparam int CH_WIDTH   = $clog2(NUM_CLK);  // Channel index bits.

	// Gate window limits, in hw cycles.
	localparam logic [GATE_WIDTH-1:0] MIN_GATE_LEN   = 24'd64;    // Crossing fits inside.
	localparam logic [GATE_WIDTH-1:0] RESET_GATE_LEN = 24'd1000;  // Value after reset.

	// Fixed identification word.
	localparam logic [FREQ_WIDTH-1:0] REVISION = 32'h0c1c_0001;

	// Register byte offsets.
	localparam logic [ADDR_WIDTH-1:0] REG_REVISION  = 8'h00;  // Read-only.
	localparam logic [ADDR_WIDTH-1:0] REG_GATE_LEN  = 8'h04;  // Read/write.
	localparam logic [ADDR_WIDTH-1:0] REG_WINDOWS   = 8'h08;  // Read-only.
	localparam logic [ADDR_WIDTH-1:0] REG_FREQ_BASE = 8'h10;  // One word per channel.

	// AXI response codes.
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Write channel FSM.
	typedef enum logic {
		WR_IDLE,  // Waiting for address and data together.
		WR_RESP   // Holding bvalid until bready.
	} wr_state_e;

	// Read channel FSM.
	typedef enum logic {
		RD_IDLE,  // arready high.
		RD_DATA   // Holding rvalid until rready.
	} rd_state_e;

endpackage
